//--- hw/l2_axi_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module l2_axi_bridge (
    input  wire logic                i_clk,
    input  wire logic                i_rst_n,
    input  wire l2_pkg::mem_req_t    i_mem_req,
    output logic                     o_mem_req_ready,
    output l2_pkg::mem_resp_t        o_mem_resp,
    output l2_pkg::axil_m2s_t        o_axil,
    input  wire l2_pkg::axil_s2m_t   i_axil
);

    typedef enum logic [1:0] {
        B_IDLE,
        B_AR,
        B_R,
        B_WRITE
    } state_e;

    state_e                              state_q;
    l2_pkg::mem_req_t                    req_q;
    logic [l2_pkg::WORD_SEL_BITS-1:0]    beat_q;
    logic [l2_pkg::LINE_BITS-1:0]        line_q;
    logic                                fault_q;
    logic                                resp_valid_q;
    logic                                awvalid_q;
    logic                                wvalid_q;

    assign o_mem_req_ready = (state_q == B_IDLE);

    always_comb begin
        o_mem_resp.valid = resp_valid_q;
        o_mem_resp.data  = line_q;
        o_mem_resp.fault = fault_q;
    end

    // Each line read beat addresses the next word of the line
    always_comb begin
        o_axil.awvalid = awvalid_q;
        o_axil.awaddr  = req_q.addr;
        o_axil.wvalid  = wvalid_q;
        o_axil.wdata   = req_q.data;
        o_axil.wstrb   = req_q.strb;
        o_axil.bready  = (state_q == B_WRITE);
        o_axil.arvalid = (state_q == B_AR);
        o_axil.araddr  = {req_q.addr[l2_pkg::ADDR_BITS-1:l2_pkg::OFFSET_BITS], beat_q,
                          {l2_pkg::BYTE_SEL_BITS{1'b0}}};
        o_axil.rready  = (state_q == B_R);
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_q      <= B_IDLE;
            beat_q       <= '0;
            fault_q      <= 1'b0;
            resp_valid_q <= 1'b0;
            awvalid_q    <= 1'b0;
            wvalid_q     <= 1'b0;
        end else begin
            resp_valid_q <= 1'b0;
            case (state_q)
                B_IDLE: begin
                    if (i_mem_req.valid) begin
                        req_q   <= i_mem_req;
                        beat_q  <= '0;
                        fault_q <= 1'b0;
                        if (i_mem_req.op == l2_pkg::MEM_WORD_WRITE) begin
                            awvalid_q <= 1'b1;
                            wvalid_q  <= 1'b1;
                            state_q   <= B_WRITE;
                        end else begin
                            state_q <= B_AR;
                        end
                    end
                end
                B_AR: begin
                    if (i_axil.arready) begin
                        state_q <= B_R;
                    end
                end
                B_R: begin
                    if (i_axil.rvalid) begin
                        line_q[beat_q*l2_pkg::WORD_BITS +: l2_pkg::WORD_BITS] <= i_axil.rdata;
                        // SLVERR and DECERR both have the upper response bit set
                        fault_q <= fault_q | i_axil.rresp[1];
                        if (beat_q == l2_pkg::LINE_WORDS - 1) begin
                            resp_valid_q <= 1'b1;
                            state_q      <= B_IDLE;
                        end else begin
                            beat_q  <= beat_q + 1'b1;
                            state_q <= B_AR;
                        end
                    end
                end
                B_WRITE: begin
                    if (i_axil.awready) begin
                        awvalid_q <= 1'b0;
                    end
                    if (i_axil.wready) begin
                        wvalid_q <= 1'b0;
                    end
                    if (i_axil.bvalid) begin
                        fault_q      <= i_axil.bresp[1];
                        resp_valid_q <= 1'b1;
                        state_q      <= B_IDLE;
                    end
                end
                default: begin
                    state_q <= B_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/l2_cache.sv
`timescale 1ns/100ps
`default_nettype none

module l2_cache (
    input  wire logic                i_clk,
    input  wire logic                i_rst_n,
    input  wire l2_pkg::l2_req_t     i_req,
    output logic                     o_req_ready,
    output l2_pkg::l2_resp_t         o_resp,
    output l2_pkg::mem_req_t         o_mem_req,
    input  wire logic                i_mem_req_ready,
    input  wire l2_pkg::mem_resp_t   i_mem_resp,
    input  wire logic                i_flush_valid,
    output logic                     o_flush_end
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_FILL_WAIT,
        ST_WRITE_WAIT,
        ST_FLUSH
    } state_e;

    state_e                              state_q;
    l2_pkg::l2_req_t                     req_q;
    l2_pkg::mem_req_t                    mem_q;
    l2_pkg::l2_resp_t                    resp_q;
    logic                                flush_pend_q;
    logic                                flush_end_q;
    logic [l2_pkg::INDEX_BITS-1:0]       flush_idx_q;

    logic [l2_pkg::NUM_LINES-1:0]        valid_q;
    logic [l2_pkg::TAG_BITS-1:0]         tag_q  [l2_pkg::NUM_LINES];
    logic [l2_pkg::LINE_BITS-1:0]        data_q [l2_pkg::NUM_LINES];

    logic [l2_pkg::INDEX_BITS-1:0]       idx;
    logic [l2_pkg::TAG_BITS-1:0]         tag;
    logic [l2_pkg::WORD_SEL_BITS-1:0]    word_sel;
    logic                                hit;
    logic [l2_pkg::WORD_BITS-1:0]        hit_word;
    logic [l2_pkg::WORD_BITS-1:0]        merged_word;
    logic [l2_pkg::WORD_BITS-1:0]        fill_word;

    // Address split for the request held in req_q
    assign idx      = req_q.addr[l2_pkg::OFFSET_BITS +: l2_pkg::INDEX_BITS];
    assign tag      = req_q.addr[l2_pkg::ADDR_BITS-1 -: l2_pkg::TAG_BITS];
    assign word_sel = req_q.addr[l2_pkg::BYTE_SEL_BITS +: l2_pkg::WORD_SEL_BITS];

    assign hit       = valid_q[idx] && (tag_q[idx] == tag);
    assign hit_word  = data_q[idx][word_sel*l2_pkg::WORD_BITS +: l2_pkg::WORD_BITS];
    assign fill_word = i_mem_resp.data[word_sel*l2_pkg::WORD_BITS +: l2_pkg::WORD_BITS];

    // A pending flush blocks new requests until the walk is done
    assign o_req_ready = (state_q == ST_IDLE) && !flush_pend_q;
    assign o_mem_req   = mem_q;
    assign o_flush_end = flush_end_q;

    always_comb begin
        for (int b = 0; b < l2_pkg::STRB_BITS; b++) begin
            merged_word[b*8 +: 8] = req_q.wstrb[b] ? req_q.wdata[b*8 +: 8] : hit_word[b*8 +: 8];
        end
    end

    // Read hits answer straight from the arrays in the lookup cycle
    always_comb begin
        o_resp = resp_q;
        if ((state_q == ST_LOOKUP) && (req_q.req_type == l2_pkg::REQ_READ) && hit) begin
            o_resp.valid  = 1'b1;
            o_resp.rdata  = hit_word;
            o_resp.status = l2_pkg::RESP_OKAY;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_q      <= ST_IDLE;
            mem_q.valid  <= 1'b0;
            resp_q.valid <= 1'b0;
            flush_pend_q <= 1'b0;
            flush_end_q  <= 1'b0;
            flush_idx_q  <= '0;
            valid_q      <= '0;
        end else begin
            resp_q.valid <= 1'b0;
            flush_end_q  <= 1'b0;
            if (mem_q.valid && i_mem_req_ready) begin
                mem_q.valid <= 1'b0;
            end
            case (state_q)
                ST_IDLE: begin
                    if (flush_pend_q) begin
                        flush_pend_q <= 1'b0;
                        flush_idx_q  <= '0;
                        state_q      <= ST_FLUSH;
                    end else if (i_req.valid) begin
                        req_q   <= i_req;
                        state_q <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    mem_q.addr <= req_q.addr;
                    mem_q.data <= req_q.wdata;
                    mem_q.strb <= req_q.wstrb;
                    if (req_q.req_type == l2_pkg::REQ_WRITE) begin
                        // Write-through, the line is only updated on a hit
                        mem_q.valid <= 1'b1;
                        mem_q.op    <= l2_pkg::MEM_WORD_WRITE;
                        state_q     <= ST_WRITE_WAIT;
                    end else if (hit) begin
                        state_q <= ST_IDLE;
                    end else begin
                        mem_q.valid <= 1'b1;
                        mem_q.op    <= l2_pkg::MEM_LINE_READ;
                        mem_q.addr  <= {req_q.addr[l2_pkg::ADDR_BITS-1:l2_pkg::OFFSET_BITS],
                                        {l2_pkg::OFFSET_BITS{1'b0}}};
                        state_q     <= ST_FILL_WAIT;
                    end
                end
                ST_FILL_WAIT: begin
                    if (i_mem_resp.valid) begin
                        resp_q.valid  <= 1'b1;
                        resp_q.rdata  <= i_mem_resp.fault ? '0 : fill_word;
                        resp_q.status <= i_mem_resp.fault ? l2_pkg::RESP_FAULT
                                                          : l2_pkg::RESP_OKAY;
                        if (!i_mem_resp.fault) begin
                            valid_q[idx] <= 1'b1;
                        end
                        state_q <= ST_IDLE;
                    end
                end
                ST_WRITE_WAIT: begin
                    if (i_mem_resp.valid) begin
                        resp_q.valid  <= 1'b1;
                        resp_q.rdata  <= '0;
                        resp_q.status <= i_mem_resp.fault ? l2_pkg::RESP_FAULT
                                                          : l2_pkg::RESP_OKAY;
                        state_q       <= ST_IDLE;
                    end
                end
                ST_FLUSH: begin
                    // One line is invalidated per cycle
                    valid_q[flush_idx_q] <= 1'b0;
                    flush_idx_q          <= flush_idx_q + 1'b1;
                    if (flush_idx_q == l2_pkg::NUM_LINES - 1) begin
                        flush_end_q <= 1'b1;
                        state_q     <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
            if (i_flush_valid) begin
                flush_pend_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if ((state_q == ST_LOOKUP) && (req_q.req_type == l2_pkg::REQ_WRITE) && hit) begin
            data_q[idx][word_sel*l2_pkg::WORD_BITS +: l2_pkg::WORD_BITS] <= merged_word;
        end
        // A faulting fill leaves the line untouched
        if ((state_q == ST_FILL_WAIT) && i_mem_resp.valid && !i_mem_resp.fault) begin
            data_q[idx] <= i_mem_resp.data;
            tag_q[idx]  <= tag;
        end
    end

endmodule

`default_nettype wire

//--- hw/l2_destination.sv
`timescale 1ns/100ps
`default_nettype none

module l2_destination (
    input  wire logic                        i_clk,
    input  wire logic                        i_rst_n,
    input  wire l2_pkg::l2_req_vec_t         i_l1_req,
    output logic [l2_pkg::NUM_PORTS-1:0]     o_l1_req_ready,
    output l2_pkg::l2_resp_vec_t             o_l1_resp,
    output l2_pkg::l2_req_t                  o_req,
    input  wire logic                        i_req_ready,
    input  wire l2_pkg::l2_resp_t            i_resp
);

    // Slot holding the request on its way to the cache
    l2_pkg::l2_req_t req_q;
    logic            busy_q;
    logic            owner_q;
    logic            rr_q;

    logic            sel;
    logic            accept;

    // Priority goes to rr_q, the other port is taken only when rr_q is idle
    always_comb begin
        if (i_l1_req[rr_q].valid) begin
            sel = rr_q;
        end else begin
            sel = ~rr_q;
        end
    end

    assign accept = !busy_q && i_l1_req[sel].valid;

    always_comb begin
        for (int p = 0; p < l2_pkg::NUM_PORTS; p++) begin
            o_l1_req_ready[p] = !busy_q && (sel == p[0]);
        end
    end

    assign o_req = req_q;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            req_q.valid <= 1'b0;
            busy_q      <= 1'b0;
            owner_q     <= 1'b0;
            rr_q        <= 1'b0;
        end else begin
            if (req_q.valid && i_req_ready) begin
                req_q.valid <= 1'b0;
            end
            if (i_resp.valid) begin
                busy_q <= 1'b0;
            end
            if (accept) begin
                req_q       <= i_l1_req[sel];
                req_q.valid <= 1'b1;
                busy_q      <= 1'b1;
                owner_q     <= sel;
                // The port just served loses priority to the other one
                rr_q        <= ~sel;
            end
        end
    end

    // The response pulse goes straight back to the owner with no register stage
    always_comb begin
        for (int p = 0; p < l2_pkg::NUM_PORTS; p++) begin
            o_l1_resp[p]       = i_resp;
            o_l1_resp[p].valid = i_resp.valid && (owner_q == p[0]);
        end
    end

endmodule

`default_nettype wire

//--- hw/l2_pkg.sv
`default_nettype none

package l2_pkg;

    // Address and cache geometry
    localparam int ADDR_BITS     = 32;
    localparam int WORD_BITS     = 32;
    localparam int LINE_WORDS    = 4;
    localparam int LINE_BITS     = 128;
    localparam int NUM_LINES     = 16;
    localparam int INDEX_BITS    = 4;
    localparam int OFFSET_BITS   = 4;
    localparam int TAG_BITS      = 24;
    localparam int NUM_PORTS     = 2;

    // Derived widths for byte strobes and word selection inside a line
    localparam int STRB_BITS     = WORD_BITS / 8;
    localparam int BYTE_SEL_BITS = 2;
    localparam int WORD_SEL_BITS = 2;

    typedef enum logic {
        REQ_READ  = 1'b0,
        REQ_WRITE = 1'b1
    } req_type_e;

    typedef enum logic [1:0] {
        RESP_OKAY  = 2'b00,
        RESP_FAULT = 2'b10
    } resp_status_e;

    typedef enum logic {
        MEM_LINE_READ  = 1'b0,
        MEM_WORD_WRITE = 1'b1
    } mem_op_e;

    // Request from a first-level requestor, addr is a word aligned byte address
    typedef struct packed {
        logic                  valid;
        req_type_e             req_type;
        logic [ADDR_BITS-1:0]  addr;
        logic [WORD_BITS-1:0]  wdata;
        logic [STRB_BITS-1:0]  wstrb;
    } l2_req_t;

    typedef struct packed {
        logic                  valid;
        logic [WORD_BITS-1:0]  rdata;
        resp_status_e          status;
    } l2_resp_t;

    typedef struct packed {
        logic                  valid;
        mem_op_e               op;
        logic [ADDR_BITS-1:0]  addr;
        logic [WORD_BITS-1:0]  data;
        logic [STRB_BITS-1:0]  strb;
    } mem_req_t;

    // Line data is only meaningful for a line read
    typedef struct packed {
        logic                  valid;
        logic [LINE_BITS-1:0]  data;
        logic                  fault;
    } mem_resp_t;

    typedef struct packed {
        logic                  awvalid;
        logic [ADDR_BITS-1:0]  awaddr;
        logic                  wvalid;
        logic [WORD_BITS-1:0]  wdata;
        logic [STRB_BITS-1:0]  wstrb;
        logic                  bready;
        logic                  arvalid;
        logic [ADDR_BITS-1:0]  araddr;
        logic                  rready;
    } axil_m2s_t;

    typedef struct packed {
        logic                  awready;
        logic                  wready;
        logic                  bvalid;
        logic [1:0]            bresp;
        logic                  arready;
        logic                  rvalid;
        logic [WORD_BITS-1:0]  rdata;
        logic [1:0]            rresp;
    } axil_s2m_t;

    typedef l2_req_t  [NUM_PORTS-1:0] l2_req_vec_t;
    typedef l2_resp_t [NUM_PORTS-1:0] l2_resp_vec_t;

endpackage

`default_nettype wire

//--- hw/l2_top.sv
`timescale 1ns/100ps
`default_nettype none

module l2_top (
    input  wire logic                        i_clk,
    input  wire logic                        i_rst_n,
    input  wire l2_pkg::l2_req_vec_t         i_l1_req,
    output logic [l2_pkg::NUM_PORTS-1:0]     o_l1_req_ready,
    output l2_pkg::l2_resp_vec_t             o_l1_resp,
    input  wire logic                        i_flush_valid,
    output logic                             o_flush_end,
    output l2_pkg::axil_m2s_t                o_axil,
    input  wire l2_pkg::axil_s2m_t           i_axil
);

    // Arbitrated request toward the cache
    l2_pkg::l2_req_t    cache_req;
    logic               cache_req_ready;
    l2_pkg::l2_resp_t   cache_resp;

    // Cache to memory bridge
    l2_pkg::mem_req_t   mem_req;
    logic               mem_req_ready;
    l2_pkg::mem_resp_t  mem_resp;

    l2_destination u_destination (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_l1_req       (i_l1_req),
        .o_l1_req_ready (o_l1_req_ready),
        .o_l1_resp      (o_l1_resp),
        .o_req          (cache_req),
        .i_req_ready    (cache_req_ready),
        .i_resp         (cache_resp)
    );

    l2_cache u_cache (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_req           (cache_req),
        .o_req_ready     (cache_req_ready),
        .o_resp          (cache_resp),
        .o_mem_req       (mem_req),
        .i_mem_req_ready (mem_req_ready),
        .i_mem_resp      (mem_resp),
        .i_flush_valid   (i_flush_valid),
        .o_flush_end     (o_flush_end)
    );

    l2_axi_bridge u_bridge (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_mem_req       (mem_req),
        .o_mem_req_ready (mem_req_ready),
        .o_mem_resp      (mem_resp),
        .o_axil          (o_axil),
        .i_axil          (i_axil)
    );

endmodule

`default_nettype wire

//--- tb.f
hw/l2_pkg.sv
hw/l2_destination.sv
hw/l2_cache.sv
hw/l2_axi_bridge.sv
hw/l2_top.sv
testbench/axi_lite_mem_model.sv
testbench/tb_l2_top.sv

//--- testbench/axi_lite_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module axi_lite_mem_model (
    input  wire logic                          i_clk,
    input  wire logic                          i_rst_n,
    input  wire l2_pkg::axil_m2s_t             i_axil,
    output l2_pkg::axil_s2m_t                  o_axil,
    input  wire logic [l2_pkg::ADDR_BITS-1:0]  i_peek_addr,
    output logic [l2_pkg::WORD_BITS-1:0]       o_peek_data,
    output int                                 o_ar_count,
    output int                                 o_aw_count
);

    localparam logic [31:0] ERR_BASE   = 32'hF000_0000;
    localparam logic [1:0]  AXI_OKAY   = 2'b00;
    localparam logic [1:0]  AXI_SLVERR = 2'b10;

    logic [31:0] mem [logic [31:0]];
    integer      seed = 32'he426_9e05;
    logic [1:0]  ar_wait;
    logic [1:0]  aw_wait;

    // Words never written hold a pattern built from the whole address
    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return {addr[15:0], addr[31:16]} ^ (addr << 3) ^ 32'h6b8b_4567;
    endfunction

    function automatic logic [31:0] merge_word(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                old[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return old;
    endfunction

    always @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_axil     <= '0;
            o_ar_count <= 0;
            o_aw_count <= 0;
            ar_wait    <= 2'd0;
            aw_wait    <= 2'd0;
        end else begin
            // One read beat follows every AR handshake
            if (i_axil.arvalid && o_axil.arready) begin
                o_axil.arready <= 1'b0;
                o_axil.rvalid  <= 1'b1;
                o_axil.rdata   <= (i_axil.araddr >= ERR_BASE) ? '0 : read_word(i_axil.araddr);
                o_axil.rresp   <= (i_axil.araddr >= ERR_BASE) ? AXI_SLVERR : AXI_OKAY;
                o_ar_count     <= o_ar_count + 1;
                ar_wait        <= 2'($random(seed));
            end else if (i_axil.arvalid && !o_axil.rvalid) begin
                if (ar_wait == 2'd0) begin
                    o_axil.arready <= 1'b1;
                end else begin
                    ar_wait <= ar_wait - 2'd1;
                end
            end
            if (o_axil.rvalid && i_axil.rready) begin
                o_axil.rvalid <= 1'b0;
            end
            // AWREADY and WREADY rise together, so both channels complete on one edge
            if (i_axil.awvalid && o_axil.awready && i_axil.wvalid && o_axil.wready) begin
                o_axil.awready <= 1'b0;
                o_axil.wready  <= 1'b0;
                o_axil.bvalid  <= 1'b1;
                o_axil.bresp   <= (i_axil.awaddr >= ERR_BASE) ? AXI_SLVERR : AXI_OKAY;
                o_aw_count     <= o_aw_count + 1;
                aw_wait        <= 2'($random(seed));
                if (i_axil.awaddr < ERR_BASE) begin
                    mem[i_axil.awaddr] = merge_word(read_word(i_axil.awaddr), i_axil.wdata,
                                                    i_axil.wstrb);
                end
            end else if (i_axil.awvalid && i_axil.wvalid && !o_axil.bvalid) begin
                if (aw_wait == 2'd0) begin
                    o_axil.awready <= 1'b1;
                    o_axil.wready  <= 1'b1;
                end else begin
                    aw_wait <= aw_wait - 2'd1;
                end
            end
            if (o_axil.bvalid && i_axil.bready) begin
                o_axil.bvalid <= 1'b0;
            end
        end
        o_peek_data <= read_word(i_peek_addr);
    end

endmodule

`default_nettype wire

//--- testbench/tb_l2_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_l2_top;

    localparam int CLK_HALF_NS   = 2;
    localparam int RESET_CYCLES  = 10;
    // Time allowed for one test with every memory access at its longest delay
    localparam int TEST_BOUND_NS = 3000;
    localparam int WATCHDOG_NS   = 6 * TEST_BOUND_NS + 2000;

    localparam logic [31:0] ADDR_A   = 32'h0000_1040;
    localparam logic [31:0] ADDR_C   = 32'h0000_2080;
    localparam logic [31:0] ADDR_P0  = 32'h0000_3000;
    localparam logic [31:0] ADDR_P1  = 32'h0000_3414;
    localparam logic [31:0] ADDR_ERR = 32'hF000_0100;
    localparam logic [31:0] ADDR_F   = 32'h0000_1850;

    logic                          clk;
    logic                          rst_n;
    l2_pkg::l2_req_vec_t           l1_req;
    logic [l2_pkg::NUM_PORTS-1:0]  l1_req_ready;
    l2_pkg::l2_resp_vec_t          l1_resp;
    logic                          flush_valid;
    logic                          flush_end;
    l2_pkg::axil_m2s_t             axil_m2s;
    l2_pkg::axil_s2m_t             axil_s2m;
    logic [31:0]                   peek_addr;
    logic [31:0]                   peek_data;
    int                            ar_count;
    int                            aw_count;
    int                            errors;
    logic [31:0]                   ref_mem [logic [31:0]];

    l2_top u_l2_top (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_l1_req       (l1_req),
        .o_l1_req_ready (l1_req_ready),
        .o_l1_resp      (l1_resp),
        .i_flush_valid  (flush_valid),
        .o_flush_end    (flush_end),
        .o_axil         (axil_m2s),
        .i_axil         (axil_s2m)
    );

    axi_lite_mem_model u_mem (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_axil      (axil_m2s),
        .o_axil      (axil_s2m),
        .i_peek_addr (peek_addr),
        .o_peek_data (peek_data),
        .o_ar_count  (ar_count),
        .o_aw_count  (aw_count)
    );

    initial clk = 1'b0;
    always #CLK_HALF_NS clk = ~clk;

    // Reference memory starts with the same address pattern as the model
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        if (ref_mem.exists(addr)) begin
            return ref_mem[addr];
        end
        return {addr[15:0], addr[31:16]} ^ (addr << 3) ^ 32'h6b8b_4567;
    endfunction

    function automatic void ref_write(input logic [31:0] addr, input logic [31:0] data,
                                      input logic [3:0] strb);
        logic [31:0] word;
        word = expected_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                word[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        ref_mem[addr] = word;
    endfunction

    task automatic check_resp(input string what, input l2_pkg::l2_resp_t got,
                              input l2_pkg::resp_status_e exp_status, input logic check_data,
                              input logic [l2_pkg::WORD_BITS-1:0] exp_data);
        if (got.status !== exp_status) begin
            errors++;
            $display("[ERROR] %0d ns: %s status %0d, expected %0d", $time, what, got.status,
                     exp_status);
        end
        if (check_data && (got.rdata !== exp_data)) begin
            errors++;
            $display("[ERROR] %0d ns: %s data %h, expected %h", $time, what, got.rdata, exp_data);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("[ERROR] %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input string what, input logic [l2_pkg::WORD_BITS-1:0] got,
                              input logic [l2_pkg::WORD_BITS-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flush(input int pulses);
        if (pulses != 1) begin
            errors++;
            $display("[ERROR] %0d ns: flush end pulsed %0d times, expected once", $time, pulses);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // Drives one request on a port and returns its response and the cycles it took
    task automatic run_request(input int port, input l2_pkg::req_type_e kind,
                               input logic [31:0] addr, input logic [31:0] wdata,
                               input logic [3:0] wstrb, output l2_pkg::l2_resp_t resp,
                               output int latency, output time done_at);
        l2_pkg::l2_req_t req;
        req.valid    = 1'b1;
        req.req_type = kind;
        req.addr     = addr;
        req.wdata    = wdata;
        req.wstrb    = wstrb;
        @(negedge clk);
        l1_req[port] = req;
        do begin
            @(posedge clk);
        end while (!l1_req_ready[port]);
        @(negedge clk);
        l1_req[port].valid = 1'b0;
        latency = 0;
        do begin
            @(posedge clk);
            latency++;
        end while (!l1_resp[port].valid);
        resp    = l1_resp[port];
        done_at = $time;
    endtask

    // Port 0 access with checks on the response and on the AXI traffic it caused
    task automatic access(input string what, input l2_pkg::req_type_e kind,
                          input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [3:0] wstrb, input l2_pkg::resp_status_e exp_status,
                          input int exp_ar, input int exp_aw, output int latency);
        l2_pkg::l2_resp_t resp;
        int               ar_before;
        int               aw_before;
        time              done_at;
        ar_before = ar_count;
        aw_before = aw_count;
        if ((kind == l2_pkg::REQ_WRITE) && (exp_status == l2_pkg::RESP_OKAY)) begin
            ref_write(addr, wdata, wstrb);
        end
        run_request(0, kind, addr, wdata, wstrb, resp, latency, done_at);
        check_resp(what, resp, exp_status,
                   (kind == l2_pkg::REQ_READ) && (exp_status == l2_pkg::RESP_OKAY),
                   expected_word(addr));
        check_count({what, " AR count"}, ar_count - ar_before, exp_ar);
        check_count({what, " AW count"}, aw_count - aw_before, exp_aw);
    endtask

    task automatic peek_model(input logic [31:0] addr, output logic [31:0] data);
        @(negedge clk);
        peek_addr = addr;
        @(negedge clk);
        data = peek_data;
    endtask

    task automatic read_miss_then_hit();
        int lat;
        access("read miss", l2_pkg::REQ_READ, ADDR_A, '0, '0, l2_pkg::RESP_OKAY, 4, 0, lat);
        access("read hit", l2_pkg::REQ_READ, ADDR_A + 8, '0, '0, l2_pkg::RESP_OKAY, 0, 0, lat);
        check_count("read hit latency", lat, 2);
    endtask

    task automatic write_through_merge();
        int          lat;
        logic [31:0] mem_word;
        access("write hit", l2_pkg::REQ_WRITE, ADDR_A + 4, 32'haabb_ccdd, 4'b0101,
               l2_pkg::RESP_OKAY, 0, 1, lat);
        access("read after write", l2_pkg::REQ_READ, ADDR_A + 4, '0, '0,
               l2_pkg::RESP_OKAY, 0, 0, lat);
        peek_model(ADDR_A + 4, mem_word);
        check_word("memory word after write", mem_word, expected_word(ADDR_A + 4));
    endtask

    task automatic write_miss_no_allocate();
        int lat;
        access("write miss", l2_pkg::REQ_WRITE, ADDR_C, 32'h1234_5678, 4'hf,
               l2_pkg::RESP_OKAY, 0, 1, lat);
        access("read after write miss", l2_pkg::REQ_READ, ADDR_C, '0, '0,
               l2_pkg::RESP_OKAY, 4, 0, lat);
    endtask

    task automatic two_port_arbitration();
        l2_pkg::l2_resp_t resp0;
        l2_pkg::l2_resp_t resp1;
        int               lat0;
        int               lat1;
        time              t0;
        time              t1;
        // Round-robin state starts over from port 0
        apply_reset();
        fork
            run_request(0, l2_pkg::REQ_READ, ADDR_P0, '0, '0, resp0, lat0, t0);
            run_request(1, l2_pkg::REQ_READ, ADDR_P1, '0, '0, resp1, lat1, t1);
        join
        check_resp("port 0 read", resp0, l2_pkg::RESP_OKAY, 1'b1, expected_word(ADDR_P0));
        check_resp("port 1 read", resp1, l2_pkg::RESP_OKAY, 1'b1, expected_word(ADDR_P1));
        check_count("port 0 served first", int'(t0 < t1), 1);
    endtask

    task automatic fault_responses();
        int lat;
        access("error read", l2_pkg::REQ_READ, ADDR_ERR, '0, '0, l2_pkg::RESP_FAULT, 4, 0, lat);
        access("repeated error read", l2_pkg::REQ_READ, ADDR_ERR, '0, '0,
               l2_pkg::RESP_FAULT, 4, 0, lat);
        access("error write", l2_pkg::REQ_WRITE, ADDR_ERR, 32'hdead_beef, 4'hf,
               l2_pkg::RESP_FAULT, 0, 1, lat);
    endtask

    task automatic flush_and_refill();
        int lat;
        int pulses;
        access("read before flush", l2_pkg::REQ_READ, ADDR_F, '0, '0,
               l2_pkg::RESP_OKAY, 4, 0, lat);
        access("hit before flush", l2_pkg::REQ_READ, ADDR_F, '0, '0,
               l2_pkg::RESP_OKAY, 0, 0, lat);
        @(negedge clk);
        flush_valid = 1'b1;
        @(negedge clk);
        flush_valid = 1'b0;
        pulses = 0;
        // The window covers the NUM_LINES + 1 cycle walk and enough cycles for a second pulse
        repeat (l2_pkg::NUM_LINES + 8) begin
            @(posedge clk);
            if (flush_end) begin
                pulses++;
            end
        end
        check_flush(pulses);
        access("read after flush", l2_pkg::REQ_READ, ADDR_F, '0, '0,
               l2_pkg::RESP_OKAY, 4, 0, lat);
    endtask

    initial begin
        errors      = 0;
        rst_n       = 1'b0;
        l1_req      = '0;
        flush_valid = 1'b0;
        peek_addr   = '0;
        apply_reset();
        read_miss_then_hit();
        write_through_merge();
        write_miss_no_allocate();
        two_port_arbitration();
        fault_responses();
        flush_and_refill();
        $display("Tests finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
